/* src/icache_params.svh */
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Fetch address and block geometry
`define ICACHE_ADDR_BITS 32
// 8-byte blocks, so three offset bits
`define ICACHE_OFFSET_BITS 3
`define ICACHE_BLOCK_BITS 64

// Fully associative line count, must be a power of two for the LRU tree
`define ICACHE_LINES 8

// Memory tags, value 0 is reserved for "no tag"
`define ICACHE_MEM_TAG_BITS 4
`define ICACHE_MSHR_DEPTH 16

// Blocks streamed after a miss once every line is valid
`define ICACHE_PREFETCH_DEPTH 7

`endif

/* src/icache_pkg.sv */
`include "icache_params.svh"

package icache_pkg;

    // --------------------
    // Address types
    // --------------------

    // Full byte address from fetch
    typedef logic [`ICACHE_ADDR_BITS-1:0] addr_t;

    // Block number with the byte offset stripped
    // Also used as the cache tag since the cache is fully associative
    typedef logic [`ICACHE_ADDR_BITS-`ICACHE_OFFSET_BITS-1:0] line_addr_t;

    // --------------------
    // Data and tag types
    // --------------------

    // One 8-byte block of instructions
    typedef logic [`ICACHE_BLOCK_BITS-1:0] block_t;

    // Memory transaction tag, zero means no transaction
    typedef logic [`ICACHE_MEM_TAG_BITS-1:0] mem_tag_t;

    // --------------------
    // Cache line index
    // --------------------

    localparam int LINE_IDX_BITS = $clog2(`ICACHE_LINES);

    // Selects one of the cache lines
    typedef logic [LINE_IDX_BITS-1:0] line_idx_t;

endpackage

/* src/plru_tree.sv */
`include "icache_params.svh"

module plru_tree (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  i_touch_valid,
    input  icache_pkg::line_idx_t i_touch_index,
    output icache_pkg::line_idx_t o_victim_index
);
    import icache_pkg::*;

    localparam int LINES = `ICACHE_LINES;
    localparam int NODES = LINES - 1;
    localparam int IDX_BITS = $bits(line_idx_t);

    // Heap order, node n has children 2n+1 and 2n+2
    // A set bit means the right subtree is older
    logic [NODES-1:0] tree_q;
    logic [NODES-1:0] tree_d;

    // Node visited at a given depth on the way to a leaf
    function automatic int path_node(input line_idx_t idx, input int level);
        return (1 << level) - 1 + (int'(idx) >> (IDX_BITS - level));
    endfunction

    // Follow the older side from the root down to a leaf
    function automatic line_idx_t victim_of(input logic [NODES-1:0] tree);
        int node;
        line_idx_t idx;
        node = 0;
        idx = '0;
        for (int level = 0; level < IDX_BITS; level++) begin
            idx[IDX_BITS-1-level] = tree[node];
            node = 2 * node + 1 + int'(tree[node]);
        end
        return idx;
    endfunction

    // --------------------
    // Touch update
    // --------------------

    // Each node on the path points at the side not taken
    always_comb begin
        tree_d = tree_q;
        if (i_touch_valid) begin
            for (int level = 0; level < IDX_BITS; level++) begin
                tree_d[path_node(i_touch_index, level)] = ~i_touch_index[IDX_BITS-1-level];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            tree_q <= '0;
        end else begin
            tree_q <= tree_d;
        end
    end

    assign o_victim_index = victim_of(tree_q);

    // The cache must hand over a resolved index on every fill
    a_touch_known: assert property (
        @(posedge clock) disable iff (reset) i_touch_valid |-> !$isunknown(i_touch_index)
    );

endmodule

/* src/icache_lines.sv */
`include "icache_params.svh"

module icache_lines (
    input  logic                       clock,
    input  logic                       reset,
    input  logic [1:0]                 i_fetch_valid,
    input  icache_pkg::addr_t [1:0]    i_fetch_addr,
    input  icache_pkg::line_addr_t     i_snoop_line,
    input  logic                       i_fill_valid,
    input  icache_pkg::line_addr_t     i_fill_line,
    input  icache_pkg::block_t         i_fill_data,
    output logic [1:0]                 o_hit,
    output icache_pkg::block_t [1:0]   o_data,
    output logic                       o_snoop_hit,
    output logic                       o_full
);
    import icache_pkg::*;

    localparam int LINES = `ICACHE_LINES;
    localparam int ADDR_BITS = `ICACHE_ADDR_BITS;
    localparam int OFFSET = `ICACHE_OFFSET_BITS;

    // Per-line state
    logic [LINES-1:0] valid_q;
    line_addr_t       tag_q [LINES];
    block_t           data_q [LINES];

    // One match vector per fetch port
    logic [LINES-1:0] match [2];

    // Fill slot choice
    line_idx_t free_idx;
    line_idx_t victim_idx;
    line_idx_t fill_idx;

    // --------------------
    // Dual lookup
    // --------------------

    // Both ports compare against every line in parallel
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            o_hit[p] = 1'b0;
            o_data[p] = '0;
            for (int i = 0; i < LINES; i++) begin
                match[p][i] = i_fetch_valid[p] && valid_q[i]
                              && (tag_q[i] == i_fetch_addr[p][ADDR_BITS-1:OFFSET]);
                if (match[p][i]) begin
                    o_hit[p] = 1'b1;
                    o_data[p] = data_q[i];
                end
            end
        end
    end

    // Prefetch candidate presence
    always_comb begin
        o_snoop_hit = 1'b0;
        for (int i = 0; i < LINES; i++) begin
            if (valid_q[i] && (tag_q[i] == i_snoop_line)) begin
                o_snoop_hit = 1'b1;
            end
        end
    end

    // --------------------
    // Fill slot choice
    // --------------------

    assign o_full = &valid_q;

    // Scan downward so the lowest free line is kept
    always_comb begin
        free_idx = '0;
        for (int i = LINES - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_idx = line_idx_t'(i);
            end
        end
    end

    // Evict only when nothing is free
    assign fill_idx = o_full ? victim_idx : free_idx;

    // Replacement state follows fills only
    plru_tree u_plru (
        .clock         (clock),
        .reset         (reset),
        .i_touch_valid (i_fill_valid),
        .i_touch_index (fill_idx),
        .o_victim_index(victim_idx)
    );

    // --------------------
    // Line write
    // --------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
        end else if (i_fill_valid) begin
            valid_q[fill_idx] <= 1'b1;
        end
    end

    // Tag and data written together with the valid bit
    always_ff @(posedge clock) begin
        if (i_fill_valid) begin
            tag_q[fill_idx] <= i_fill_line;
            data_q[fill_idx] <= i_fill_data;
        end
    end

    // Snoop suppression in the prefetcher keeps every block in one line at most
    for (genvar p = 0; p < 2; p++) begin : g_unique_hit
        a_unique_hit: assert property (
            @(posedge clock) disable iff (reset) $onehot0(match[p])
        );
    end

endmodule

/* src/fill_mshr.sv */
`include "icache_params.svh"

module fill_mshr (
    input  logic                   clock,
    input  logic                   reset,
    input  icache_pkg::line_addr_t i_snoop_line,
    input  logic                   i_push,
    input  icache_pkg::mem_tag_t   i_push_tag,
    input  icache_pkg::line_addr_t i_push_line,
    input  icache_pkg::mem_tag_t   i_ret_tag,
    output logic                   o_snoop_hit,
    output logic                   o_fill_valid,
    output icache_pkg::line_addr_t o_fill_line
);
    import icache_pkg::*;

    localparam int DEPTH = `ICACHE_MSHR_DEPTH;
    localparam int PTR_BITS = $clog2(DEPTH);

    // Entry storage
    logic [DEPTH-1:0] valid_q;
    mem_tag_t         tag_q [DEPTH];
    line_addr_t       line_q [DEPTH];

    // Circular pointers
    logic [PTR_BITS-1:0] head_q;
    logic [PTR_BITS-1:0] tail_q;

    logic push_ok;
    logic pop;
    logic full;

    function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Tag 0 from memory means the request was not really taken
    assign push_ok = i_push && (i_push_tag != '0);

    // Tail slot still occupied
    assign full = valid_q[tail_q];

    // In-order returns only, other tags are dropped
    assign pop = valid_q[head_q] && (i_ret_tag != '0) && (i_ret_tag == tag_q[head_q]);

    assign o_fill_valid = pop;
    assign o_fill_line = line_q[head_q];

    // Any in-flight entry counts as a duplicate
    always_comb begin
        o_snoop_hit = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            if (valid_q[i] && (line_q[i] == i_snoop_line)) begin
                o_snoop_hit = 1'b1;
            end
        end
    end

    // --------------------
    // Pointer and valid update
    // --------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            head_q <= '0;
            tail_q <= '0;
            valid_q <= '0;
        end else begin
            if (pop) begin
                valid_q[head_q] <= 1'b0;
                head_q <= ptr_inc(head_q);
            end
            if (push_ok) begin
                valid_q[tail_q] <= 1'b1;
                tail_q <= ptr_inc(tail_q);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (push_ok) begin
            tag_q[tail_q] <= i_push_tag;
            line_q[tail_q] <= i_push_line;
        end
    end

    // Memory never has more tags in flight than the FIFO holds
    a_no_overflow: assert property (
        @(posedge clock) disable iff (reset) push_ok |-> !full
    );

endmodule

/* src/stream_prefetcher.sv */
`include "icache_params.svh"

module stream_prefetcher (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   i_miss_valid,
    input  icache_pkg::line_addr_t i_miss_line,
    input  logic                   i_cache_hit,
    input  logic                   i_mshr_hit,
    input  logic                   i_cache_full,
    input  logic                   i_accepted,
    output icache_pkg::line_addr_t o_snoop_line,
    output logic                   o_req_valid,
    output icache_pkg::addr_t      o_req_addr
);
    import icache_pkg::*;

    localparam int DEPTH = `ICACHE_PREFETCH_DEPTH;
    localparam int OFFSET = `ICACHE_OFFSET_BITS;
    localparam int COUNT_BITS = $clog2(DEPTH + 1);

    // Last miss already handled, forgotten once fetch stops missing
    logic       miss_seen_q;
    line_addr_t miss_line_q;

    // Stream position and length
    logic                  stream_q;
    line_addr_t            cursor_q;
    logic [COUNT_BITS-1:0] count_q;

    logic       new_miss;
    logic       cand_valid;
    line_addr_t cand_line;
    logic       suppressed;
    logic       advance;

    assign new_miss = i_miss_valid && (!miss_seen_q || (i_miss_line != miss_line_q));

    // --------------------
    // Candidate select
    // --------------------

    // Fresh miss first, then the block after the cursor
    always_comb begin
        cand_valid = 1'b0;
        cand_line = cursor_q + 1'b1;
        if (new_miss) begin
            cand_valid = 1'b1;
            cand_line = i_miss_line;
        end else if (stream_q && (!i_cache_full || (count_q < COUNT_BITS'(DEPTH)))) begin
            cand_valid = 1'b1;
        end
    end

    // Present in cache or in flight, so skip it
    assign suppressed = i_cache_hit || i_mshr_hit;
    assign o_req_valid = cand_valid && !suppressed;
    assign advance = cand_valid && (suppressed || i_accepted);

    assign o_snoop_line = cand_line;
    assign o_req_addr = {cand_line, {OFFSET{1'b0}}};

    // --------------------
    // Stream state
    // --------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            miss_seen_q <= 1'b0;
            miss_line_q <= '0;
            stream_q <= 1'b0;
            cursor_q <= '0;
            count_q <= '0;
        end else begin
            if (!i_miss_valid) begin
                miss_seen_q <= 1'b0;
            end
            if (new_miss) begin
                count_q <= '0;
            end
            if (advance) begin
                if (new_miss) begin
                    // Restart the stream at the missing block
                    miss_seen_q <= 1'b1;
                    miss_line_q <= i_miss_line;
                    stream_q <= 1'b1;
                    cursor_q <= i_miss_line;
                end else begin
                    cursor_q <= cand_line;
                    // Saturate so a long stream cannot wrap the limit
                    if (count_q != COUNT_BITS'(DEPTH)) begin
                        count_q <= count_q + 1'b1;
                    end
                end
            end
        end
    end

    // Memory sees only resolved addresses
    a_req_known: assert property (
        @(posedge clock) disable iff (reset)
        o_req_valid |-> !$isunknown(o_req_addr)
    );

endmodule

/* src/icache_subsystem.sv */
`include "icache_params.svh"

module icache_subsystem (
    input  logic                     clock,
    input  logic                     reset,
    input  logic [1:0]               i_fetch_valid,
    input  icache_pkg::addr_t [1:0]  i_fetch_addr,
    input  logic                     i_mem_req_accepted,
    input  icache_pkg::mem_tag_t     i_mem_req_tag,
    input  icache_pkg::mem_tag_t     i_mem_data_tag,
    input  icache_pkg::block_t       i_mem_data,
    output logic [1:0]               o_hit,
    output icache_pkg::block_t [1:0] o_data,
    output logic                     o_mem_req_valid,
    output icache_pkg::addr_t        o_mem_req_addr
);
    import icache_pkg::*;

    localparam int ADDR_BITS = `ICACHE_ADDR_BITS;
    localparam int OFFSET = `ICACHE_OFFSET_BITS;

    // Oldest miss handed to the prefetcher
    logic       miss_valid;
    line_addr_t miss_line;

    // Prefetcher candidate, snooped by cache and MSHR
    line_addr_t snoop_line;
    logic       cache_snoop_hit;
    logic       mshr_snoop_hit;
    logic       cache_full;

    // MSHR head pop drives the cache fill
    logic       fill_valid;
    line_addr_t fill_line;

    // --------------------
    // Oldest miss select
    // --------------------

    // Port 0 holds the older instruction, so it wins
    always_comb begin
        miss_valid = 1'b0;
        miss_line = i_fetch_addr[0][ADDR_BITS-1:OFFSET];
        if (i_fetch_valid[0] && !o_hit[0]) begin
            miss_valid = 1'b1;
        end else if (i_fetch_valid[1] && !o_hit[1]) begin
            miss_valid = 1'b1;
            miss_line = i_fetch_addr[1][ADDR_BITS-1:OFFSET];
        end
    end

    icache_lines u_lines (
        .clock        (clock),
        .reset        (reset),
        .i_fetch_valid(i_fetch_valid),
        .i_fetch_addr (i_fetch_addr),
        .i_snoop_line (snoop_line),
        .i_fill_valid (fill_valid),
        .i_fill_line  (fill_line),
        .i_fill_data  (i_mem_data),
        .o_hit        (o_hit),
        .o_data       (o_data),
        .o_snoop_hit  (cache_snoop_hit),
        .o_full       (cache_full)
    );

    // Request line equals the snoop line whenever an accept can occur
    fill_mshr u_mshr (
        .clock       (clock),
        .reset       (reset),
        .i_snoop_line(snoop_line),
        .i_push      (i_mem_req_accepted),
        .i_push_tag  (i_mem_req_tag),
        .i_push_line (snoop_line),
        .i_ret_tag   (i_mem_data_tag),
        .o_snoop_hit (mshr_snoop_hit),
        .o_fill_valid(fill_valid),
        .o_fill_line (fill_line)
    );

    stream_prefetcher u_prefetch (
        .clock       (clock),
        .reset       (reset),
        .i_miss_valid(miss_valid),
        .i_miss_line (miss_line),
        .i_cache_hit (cache_snoop_hit),
        .i_mshr_hit  (mshr_snoop_hit),
        .i_cache_full(cache_full),
        .i_accepted  (i_mem_req_accepted),
        .o_snoop_line(snoop_line),
        .o_req_valid (o_mem_req_valid),
        .o_req_addr  (o_mem_req_addr)
    );

endmodule

/* sim/icache_subsystem_tb.sv */
`include "icache_params.svh"

module icache_subsystem_tb;
    import icache_pkg::*;

    localparam int ADDR_BITS = `ICACHE_ADDR_BITS;
    localparam int OFFSET = `ICACHE_OFFSET_BITS;
    localparam int HALF = `ICACHE_BLOCK_BITS / 2;
    localparam int MAX_TAG = (1 << `ICACHE_MEM_TAG_BITS) - 1;
    localparam int STREAM_LEN = 1 + `ICACHE_PREFETCH_DEPTH;
    localparam int TIMEOUT = 200;
    localparam int MEM_LATENCY = 6;
    localparam int QUIET_CYCLES = 12;

    // DUT signals
    logic         clock;
    logic         reset;
    logic [1:0]   fetch_valid;
    addr_t [1:0]  fetch_addr;
    logic         mem_req_accepted;
    mem_tag_t     mem_req_tag;
    mem_tag_t     mem_data_tag;
    block_t       mem_data;
    logic [1:0]   hit;
    block_t [1:0] data;
    logic         mem_req_valid;
    addr_t        mem_req_addr;

    integer seed;
    int     errors;
    int     failed_tests;
    int     cycle = 0;
    logic   req_taken;

    // Memory model in-flight list, one entry per accepted request
    addr_t    pend_addr [$];
    mem_tag_t pend_tag [$];
    int       pend_ret [$];
    // All accepted request addresses, cleared by the tests
    addr_t    req_log [$];

    icache_subsystem uut (
        .clock             (clock),
        .reset             (reset),
        .i_fetch_valid     (fetch_valid),
        .i_fetch_addr      (fetch_addr),
        .i_mem_req_accepted(mem_req_accepted),
        .i_mem_req_tag     (mem_req_tag),
        .i_mem_data_tag    (mem_data_tag),
        .i_mem_data        (mem_data),
        .o_hit             (hit),
        .o_data            (data),
        .o_mem_req_valid   (mem_req_valid),
        .o_mem_req_addr    (mem_req_addr)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    // --------------------
    // Reference model
    // --------------------

    // Line address in the low half, its inverse in the high half
    function automatic block_t ref_block(input line_addr_t line);
        logic [HALF-1:0] half;
        half = HALF'(line);
        return {~half, half};
    endfunction

    function automatic line_addr_t line_of(input addr_t addr);
        return addr[ADDR_BITS-1:OFFSET];
    endfunction

    // Aligned address k blocks past the given line
    function automatic addr_t block_addr(input line_addr_t line, input int k);
        line_addr_t l;
        l = line + line_addr_t'(k);
        return {l, {OFFSET{1'b0}}};
    endfunction

    // --------------------
    // Memory model
    // --------------------

    // Every request is taken in the cycle it is offered
    assign mem_req_accepted = mem_req_valid;

    // Record requests mid-cycle and flag repeats of in-flight blocks
    always @(negedge clock) begin
        if (!reset && mem_req_valid) begin
            foreach (pend_addr[i]) begin
                if (pend_addr[i] == mem_req_addr) begin
                    errors++;
                    $display("ERR %0t duplicate request for %h while in flight",
                             $time, mem_req_addr);
                end
            end
            pend_addr.push_back(mem_req_addr);
            pend_tag.push_back(mem_req_tag);
            pend_ret.push_back(cycle + MEM_LATENCY);
            req_log.push_back(mem_req_addr);
            req_taken = 1'b1;
        end
    end

    // Tag rotation and in-order data return
    always @(posedge clock) begin
        #5;
        if (req_taken) begin
            mem_req_tag = (mem_req_tag == MAX_TAG) ? mem_tag_t'(1) : mem_req_tag + 1'b1;
            req_taken = 1'b0;
        end
        mem_data_tag = '0;
        if (pend_ret.size() > 0 && pend_ret[0] == cycle) begin
            mem_data_tag = pend_tag[0];
            mem_data = ref_block(line_of(pend_addr[0]));
            void'(pend_addr.pop_front());
            void'(pend_tag.pop_front());
            void'(pend_ret.pop_front());
        end
    end

    // Any hit on either port must carry its block's data
    always @(negedge clock) begin
        if (!reset) begin
            for (int p = 0; p < 2; p++) begin
                if (fetch_valid[p] && hit[p]) begin
                    check_block($sformatf("port %0d hit data", p), data[p],
                                ref_block(line_of(fetch_addr[p])));
                end
            end
        end
    end

    // --------------------
    // Compare tasks
    // --------------------

    task automatic check_block(input string what, input block_t got, input block_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input string what, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // --------------------
    // Timing helpers
    // --------------------

    task automatic next_drive_point();
        @(posedge clock);
        #5;
    endtask

    // Mid-cycle, after the memory monitor has run
    task automatic sample_point();
        @(negedge clock);
        #1;
    endtask

    task automatic drive_fetch(input logic [1:0] valid, input addr_t a0, input addr_t a1);
        next_drive_point();
        fetch_valid = valid;
        fetch_addr[0] = a0;
        fetch_addr[1] = a1;
    endtask

    task automatic wait_hit(input logic [1:0] mask, output bit ok);
        int n;
        ok = 1'b0;
        n = 0;
        while (!ok && n < TIMEOUT) begin
            sample_point();
            ok = ((hit & mask) == mask);
            n++;
        end
        if (!ok) begin
            errors++;
            $display("timeout: fetch ports %b did not hit within %0d cycles", mask, TIMEOUT);
        end
    endtask

    task automatic wait_request(output bit ok);
        int n;
        ok = 1'b0;
        n = 0;
        while (!ok && n < TIMEOUT) begin
            sample_point();
            ok = mem_req_valid;
            n++;
        end
        if (!ok) begin
            errors++;
            $display("timeout: no memory request within %0d cycles", TIMEOUT);
        end
    endtask

    // No request and nothing in flight for several cycles in a row
    task automatic wait_quiet();
        int n;
        int quiet;
        n = 0;
        quiet = 0;
        while (quiet < QUIET_CYCLES && n < TIMEOUT) begin
            sample_point();
            if (!mem_req_valid && pend_addr.size() == 0) begin
                quiet++;
            end else begin
                quiet = 0;
            end
            n++;
        end
        if (quiet < QUIET_CYCLES) begin
            errors++;
            $display("timeout: memory traffic did not stop within %0d cycles", TIMEOUT);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: failed with %0d errors", name, errors - errs_before);
        end
    endtask

    // --------------------
    // Test sequence
    // --------------------

    initial begin
        addr_t      a;
        addr_t      b;
        line_addr_t line;
        bit         ok;
        int         base;

        seed = 32'hd746f043;
        reset = 1'b1;
        fetch_valid = '0;
        fetch_addr = '0;
        mem_req_tag = mem_tag_t'(1);
        mem_data_tag = '0;
        mem_data = '0;
        req_taken = 1'b0;
        errors = 0;
        failed_tests = 0;
        repeat (10) @(posedge clock);
        #5;
        reset = 1'b0;

        // Idle fetch right after reset
        base = errors;
        sample_point();
        check_flag("request valid after reset", mem_req_valid, 1'b0);
        check_flag("port 0 hit after reset", hit[0], 1'b0);
        check_flag("port 1 hit after reset", hit[1], 1'b0);
        end_test("reset state", base);

        // Cold miss on an empty cache
        base = errors;
        a = addr_t'($random(seed));
        drive_fetch(2'b01, a, '0);
        wait_request(ok);
        if (ok) begin
            check_addr("cold miss request", mem_req_addr, block_addr(line_of(a), 0));
        end
        wait_hit(2'b01, ok);
        if (ok) begin
            check_block("cold miss data", data[0], ref_block(line_of(a)));
        end
        drive_fetch(2'b00, '0, '0);
        wait_quiet();
        end_test("cold miss", base);

        // Both ports hit on neighbouring blocks
        base = errors;
        a = addr_t'($random(seed));
        drive_fetch(2'b11, a, block_addr(line_of(a), 1));
        wait_hit(2'b11, ok);
        if (ok) begin
            check_block("port 0 data", data[0], ref_block(line_of(a)));
            check_block("port 1 data", data[1], ref_block(line_of(a) + 1'b1));
        end
        drive_fetch(2'b00, '0, '0);
        wait_quiet();
        // Two misses, port 0 is served first
        a = addr_t'($random(seed));
        b = addr_t'($random(seed));
        drive_fetch(2'b11, a, b);
        wait_request(ok);
        if (ok) begin
            check_addr("oldest miss request", mem_req_addr, block_addr(line_of(a), 0));
        end
        wait_hit(2'b01, ok);
        drive_fetch(2'b00, '0, '0);
        wait_quiet();
        end_test("two-port lookup", base);

        // Miss then sequential prefetch on a full cache
        base = errors;
        a = addr_t'($random(seed));
        line = line_of(a);
        req_log.delete();
        drive_fetch(2'b01, a, '0);
        wait_hit(2'b01, ok);
        drive_fetch(2'b00, '0, '0);
        wait_quiet();
        if (req_log.size() != STREAM_LEN) begin
            errors++;
            $display("ERR %0t prefetch stream gave %0d requests instead of %0d",
                     $time, req_log.size(), STREAM_LEN);
        end
        for (int k = 0; k < req_log.size() && k < STREAM_LEN; k++) begin
            check_addr($sformatf("stream request %0d", k), req_log[k], block_addr(line, k));
        end
        req_log.delete();
        drive_fetch(2'b01, block_addr(line, 1), '0);
        sample_point();
        check_flag("prefetched block hit", hit[0], 1'b1);
        check_block("prefetched block data", data[0], ref_block(line + 1'b1));
        repeat (3) sample_point();
        drive_fetch(2'b00, '0, '0);
        if (req_log.size() != 0) begin
            errors++;
            $display("ERR %0t %0d requests issued while fetching a prefetched block",
                     $time, req_log.size());
        end
        end_test("prefetch stream", base);

        // Several streams force replacement, then sweep the newest one
        base = errors;
        for (int s = 0; s < 3; s++) begin
            a = addr_t'($random(seed));
            drive_fetch(2'b01, a, '0);
            wait_hit(2'b01, ok);
            drive_fetch(2'b00, '0, '0);
            wait_quiet();
        end
        line = line_of(a);
        for (int k = 0; k < STREAM_LEN; k++) begin
            drive_fetch(2'b01, block_addr(line, k), '0);
            sample_point();
            check_flag($sformatf("sweep block %0d hit", k), hit[0], 1'b1);
            check_block($sformatf("sweep block %0d data", k), data[0], ref_block(line + k));
        end
        drive_fetch(2'b00, '0, '0);
        end_test("no duplicates and replacement", base);

        $display("summary: 5 tests, %0d failed, %0d errors", failed_tests, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* icache_subsystem.f */
+incdir+src
src/icache_pkg.sv
src/plru_tree.sv
src/icache_lines.sv
src/fill_mshr.sv
src/stream_prefetcher.sv
src/icache_subsystem.sv
sim/icache_subsystem_tb.sv
